// ==== source/corePkg.sv ====
package corePkg;

    localparam int xlen = 32;

    typedef logic [4:0] regAddrT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluSrl,
        aluPassB
    } aluOpT;

    typedef enum logic [1:0] {
        immI,
        immB,
        immJ,
        immNone
    } immFmtT;

    typedef struct packed {
        logic  regWrite;
        aluOpT aluOp;
        logic  aluSrcImm;
        logic  branch;
        logic  branchNe;
        logic  jump;
        logic  linkPc;
        logic  valid;
    } decodeCtrlT;

    typedef struct packed {
        logic [xlen-1:0] rs1Val;
        logic [xlen-1:0] rs2Val;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] pcPlus4;
        logic [xlen-1:0] imm;
        regAddrT         rs1;
        regAddrT         rs2;
        regAddrT         rd;
    } decodeDataT;

    typedef struct packed {
        logic            valid;
        logic            write;
        regAddrT         rd;
        logic [xlen-1:0] data;
        logic [xlen-1:0] pc;
    } retireT;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] target;
    } redirectT;

    // Bubbles carry valid low and never write
    localparam decodeCtrlT ctrlBubble   = '0;
    localparam decodeDataT dataBubble   = '0;
    localparam retireT     retireBubble = '0;

endpackage

// ==== source/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit import corePkg::*; (
    input  logic [31:0] instr,
    input  logic        instrValid,
    input  logic        hold,
    input  logic        taken,
    output decodeCtrlT  ctrlD,
    output immFmtT      immFmt,
    output logic        stall,
    output logic        flush
);

    localparam logic [6:0] opReg  = 7'b0110011;
    localparam logic [6:0] opImm  = 7'b0010011;
    localparam logic [6:0] opBr   = 7'b1100011;
    localparam logic [6:0] opJal  = 7'b1101111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    decodeCtrlT dec;
    immFmtT     fmt;
    logic       supported;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        dec       = ctrlBubble;
        fmt       = immNone;
        supported = 1'b1;
        case (opcode)
            opReg: begin
                dec.regWrite = 1'b1;
                // Only sub uses the alternate funct7
                if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    dec.aluOp = aluSub;
                end else if (funct7 != 7'b0000000) begin
                    supported = 1'b0;
                end else begin
                    case (funct3)
                        3'b000:  dec.aluOp = aluAdd;
                        3'b001:  dec.aluOp = aluSll;
                        3'b010:  dec.aluOp = aluSlt;
                        3'b100:  dec.aluOp = aluXor;
                        3'b101:  dec.aluOp = aluSrl;
                        3'b110:  dec.aluOp = aluOr;
                        3'b111:  dec.aluOp = aluAnd;
                        default: supported = 1'b0;
                    endcase
                end
            end
            opImm: begin
                dec.regWrite  = 1'b1;
                dec.aluSrcImm = 1'b1;
                fmt           = immI;
                case (funct3)
                    3'b000:  dec.aluOp = aluAdd;
                    3'b010:  dec.aluOp = aluSlt;
                    3'b100:  dec.aluOp = aluXor;
                    3'b110:  dec.aluOp = aluOr;
                    3'b111:  dec.aluOp = aluAnd;
                    default: supported = 1'b0;
                endcase
            end
            opBr: begin
                dec.branch = 1'b1;
                fmt        = immB;
                case (funct3)
                    3'b000:  dec.branchNe = 1'b0;
                    3'b001:  dec.branchNe = 1'b1;
                    default: supported = 1'b0;
                endcase
            end
            opJal: begin
                dec.regWrite = 1'b1;
                dec.jump     = 1'b1;
                dec.linkPc   = 1'b1;
                dec.aluOp    = aluPassB;
                fmt          = immJ;
            end
            default: supported = 1'b0;
        endcase
        dec.valid = 1'b1;
    end

    // Invalid or unknown instructions decode as a bubble
    always_comb begin
        if (instrValid && supported) begin
            ctrlD  = dec;
            immFmt = fmt;
        end else begin
            ctrlD  = ctrlBubble;
            immFmt = immNone;
        end
    end

    assign stall = hold;
    // Wrong-path instruction in decode is dropped once hold releases
    assign flush = taken & ~hold;

endmodule

// ==== source/immExtend.sv ====
`timescale 1ns/1ps

module immExtend import corePkg::*; (
    input  logic [31:0]     instr,
    input  immFmtT          immFmt,
    output logic [xlen-1:0] imm
);

    logic [xlen-1:0] immIVal;
    logic [xlen-1:0] immBVal;
    logic [xlen-1:0] immJVal;

    assign immIVal = {{20{instr[31]}}, instr[31:20]};

    // Branch offset bits are scattered, bit 0 always zero
    assign immBVal = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                      instr[11:8], 1'b0};

    assign immJVal = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                      instr[30:21], 1'b0};

    always_comb begin
        case (immFmt)
            immI:    imm = immIVal;
            immB:    imm = immBVal;
            immJ:    imm = immJVal;
            default: imm = '0;
        endcase
    end

endmodule

// ==== source/registerFile.sv ====
`timescale 1ns/1ps

module registerFile import corePkg::*; #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rstN,
    input  regAddrT          rs1,
    input  regAddrT          rs2,
    input  logic             writeEn,
    input  regAddrT          rd,
    input  logic [WIDTH-1:0] writeData,
    output logic [WIDTH-1:0] rs1Val,
    output logic [WIDTH-1:0] rs2Val
);

    logic [WIDTH-1:0] regs [32];
    logic             writeLive;

    // x0 is never stored
    assign writeLive = writeEn && (rd != '0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeLive) begin
            regs[rd] <= writeData;
        end
    end

    // Write-through so decode sees the retiring value
    always_comb begin
        if (rs1 == '0)
            rs1Val = '0;
        else if (writeLive && rd == rs1)
            rs1Val = writeData;
        else
            rs1Val = regs[rs1];

        if (rs2 == '0)
            rs2Val = '0;
        else if (writeLive && rd == rs2)
            rs2Val = writeData;
        else
            rs2Val = regs[rs2];
    end

endmodule

// ==== source/stageRegister.sv ====
`timescale 1ns/1ps

module stageRegister #(
    parameter type     payloadT = logic,
    parameter payloadT bubble   = '0
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    stall,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // Stall wins over flush
    always_ff @(posedge clk) begin
        if (!rstN) begin
            q <= bubble;
        end else if (!stall) begin
            if (flush)
                q <= bubble;
            else
                q <= d;
        end
    end

endmodule

// ==== source/executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit import corePkg::*; #(
    parameter int WIDTH = 32
) (
    input  decodeCtrlT ctrlE,
    input  decodeDataT dataE,
    input  retireT     wbFwd,
    output logic       taken,
    output redirectT   redirect,
    output retireT     result
);

    logic [WIDTH-1:0] rs1Fwd;
    logic [WIDTH-1:0] rs2Fwd;
    logic [WIDTH-1:0] aluB;
    logic [WIDTH-1:0] aluOut;
    logic [4:0]       shamt;
    logic             fwdLive;
    logic             operandsEq;
    logic             branchTaken;

    // Only a writing, nonzero rd in writeback can forward
    assign fwdLive = wbFwd.write && (wbFwd.rd != '0);

    assign rs1Fwd = (fwdLive && wbFwd.rd == dataE.rs1) ? wbFwd.data : dataE.rs1Val;
    assign rs2Fwd = (fwdLive && wbFwd.rd == dataE.rs2) ? wbFwd.data : dataE.rs2Val;

    assign aluB  = ctrlE.aluSrcImm ? dataE.imm : rs2Fwd;
    assign shamt = aluB[4:0];

    always_comb begin
        case (ctrlE.aluOp)
            aluAdd:   aluOut = rs1Fwd + aluB;
            aluSub:   aluOut = rs1Fwd - aluB;
            aluAnd:   aluOut = rs1Fwd & aluB;
            aluOr:    aluOut = rs1Fwd | aluB;
            aluXor:   aluOut = rs1Fwd ^ aluB;
            aluSlt:   aluOut = {{(WIDTH-1){1'b0}}, $signed(rs1Fwd) < $signed(aluB)};
            aluSll:   aluOut = rs1Fwd << shamt;
            aluSrl:   aluOut = rs1Fwd >> shamt;
            aluPassB: aluOut = aluB;
            default:  aluOut = '0;
        endcase
    end

    // Branch compare always uses rs2, never the immediate
    assign operandsEq  = (rs1Fwd == rs2Fwd);
    assign branchTaken = ctrlE.branch && (ctrlE.branchNe ? !operandsEq : operandsEq);
    assign taken       = ctrlE.valid && (branchTaken || ctrlE.jump);

    always_comb begin
        redirect.valid  = taken;
        redirect.target = dataE.pc + dataE.imm;
    end

    always_comb begin
        result.valid = ctrlE.valid;
        result.write = ctrlE.valid && ctrlE.regWrite;
        result.rd    = dataE.rd;
        result.data  = ctrlE.linkPc ? dataE.pcPlus4 : aluOut;
        result.pc    = dataE.pc;
    end

endmodule

// ==== source/decodeExecSlice.sv ====
`timescale 1ns/1ps

module decodeExecSlice import corePkg::*; #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic [31:0]      instr,
    input  logic [WIDTH-1:0] pc,
    input  logic             instrValid,
    input  logic             hold,
    output redirectT         redirect,
    output retireT           retire
);

    decodeCtrlT       ctrlD;
    decodeCtrlT       ctrlQ;
    decodeDataT       dataD;
    decodeDataT       dataQ;
    retireT           retireD;
    retireT           retireQ;
    immFmtT           immFmt;
    logic             stall;
    logic             flush;
    logic             taken;
    logic [WIDTH-1:0] rs1Val;
    logic [WIDTH-1:0] rs2Val;
    logic [WIDTH-1:0] imm;

    controlUnit u_control (
        .instr      (instr),
        .instrValid (instrValid),
        .hold       (hold),
        .taken      (taken),
        .ctrlD      (ctrlD),
        .immFmt     (immFmt),
        .stall      (stall),
        .flush      (flush)
    );

    immExtend u_imm (
        .instr  (instr),
        .immFmt (immFmt),
        .imm    (imm)
    );

    registerFile #(.WIDTH(WIDTH)) u_regs (
        .clk       (clk),
        .rstN      (rstN),
        .rs1       (instr[19:15]),
        .rs2       (instr[24:20]),
        .writeEn   (retireQ.write && !stall),
        .rd        (retireQ.rd),
        .writeData (retireQ.data),
        .rs1Val    (rs1Val),
        .rs2Val    (rs2Val)
    );

    always_comb begin
        dataD.rs1Val  = rs1Val;
        dataD.rs2Val  = rs2Val;
        dataD.pc      = pc;
        dataD.pcPlus4 = pc + 4;
        dataD.imm     = imm;
        dataD.rs1     = instr[19:15];
        dataD.rs2     = instr[24:20];
        dataD.rd      = instr[11:7];
    end

    stageRegister #(.payloadT(decodeCtrlT), .bubble(ctrlBubble)) ctrlE (
        .clk   (clk),
        .rstN  (rstN),
        .stall (stall),
        .flush (flush),
        .d     (ctrlD),
        .q     (ctrlQ)
    );

    stageRegister #(.payloadT(decodeDataT), .bubble(dataBubble)) dataE (
        .clk   (clk),
        .rstN  (rstN),
        .stall (stall),
        .flush (flush),
        .d     (dataD),
        .q     (dataQ)
    );

    executeUnit #(.WIDTH(WIDTH)) u_exec (
        .ctrlE    (ctrlQ),
        .dataE    (dataQ),
        .wbFwd    (retireQ),
        .taken    (taken),
        .redirect (redirect),
        .result   (retireD)
    );

    // Branch or jal in execute still retires, so no flush here
    stageRegister #(.payloadT(retireT), .bubble(retireBubble)) wbReg (
        .clk   (clk),
        .rstN  (rstN),
        .stall (stall),
        .flush (1'b0),
        .d     (retireD),
        .q     (retireQ)
    );

    // Held record retires once, after hold drops
    always_comb begin
        retire       = retireQ;
        retire.valid = retireQ.valid && !stall;
    end

endmodule

// ==== verification/tbDecodeExec.sv ====
`timescale 1ns/1ps

module tbDecodeExec import corePkg::*; ();

    logic            clk;
    logic            rstN;
    logic [31:0]     instr;
    logic [xlen-1:0] pc;
    logic            instrValid;
    logic            hold;
    redirectT        redirect;
    retireT          retire;

    // Reference model state
    logic [xlen-1:0] regs [32];
    logic [xlen-1:0] modelPc;
    retireT          expRetire [$];
    logic [xlen-1:0] expTarget [$];
    integer          seed;
    int              waitCycles;

    decodeExecSlice #(.WIDTH(xlen)) u_dut (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .pc         (pc),
        .instrValid (instrValid),
        .hold       (hold),
        .redirect   (redirect),
        .retire     (retire)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stopWithFail(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on first error");
    endtask

    // Small pool keeps dependencies frequent
    function automatic regAddrT pickReg();
        case ({$random(seed)} % 5)
            0:       pickReg = 5'd0;
            1:       pickReg = 5'd1;
            2:       pickReg = 5'd2;
            3:       pickReg = 5'd3;
            default: pickReg = 5'd7;
        endcase
    endfunction

    function automatic logic [2:0] funct3For(input int op);
        case (op)
            2:       funct3For = 3'b111;
            3:       funct3For = 3'b110;
            4:       funct3For = 3'b100;
            5:       funct3For = 3'b010;
            6:       funct3For = 3'b001;
            7:       funct3For = 3'b101;
            default: funct3For = 3'b000;
        endcase
    endfunction

    // op order is add sub and or xor slt sll srl
    function automatic logic [xlen-1:0] aluModel(input int op, input logic [xlen-1:0] a,
                                                 input logic [xlen-1:0] b);
        case (op)
            0:       aluModel = a + b;
            1:       aluModel = a - b;
            2:       aluModel = a & b;
            3:       aluModel = a | b;
            4:       aluModel = a ^ b;
            // Differing signs decide slt on their own
            5:       aluModel = {{(xlen-1){1'b0}},
                                 (a[xlen-1] != b[xlen-1]) ? a[xlen-1] : (a < b)};
            6:       aluModel = a << b[4:0];
            default: aluModel = a >> b[4:0];
        endcase
    endfunction

    // Drive one slot and hold it for a few random cycles before it is taken
    task automatic presentSlot(input logic [31:0] word, input logic [xlen-1:0] addr,
                               input logic vld);
        int holdCycles;
        instr      = word;
        pc         = addr;
        instrValid = vld;
        holdCycles = ({$random(seed)} % 6 == 0) ? int'({$random(seed)} % 3) + 1 : 0;
        for (int i = 0; i < holdCycles; i++) begin
            hold = 1'b1;
            @(posedge clk);
            #1;
        end
        hold = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic issueInstr();
        int              kind;
        int              op;
        regAddrT         rd;
        regAddrT         rs1;
        regAddrT         rs2;
        logic [11:0]     imm12;
        logic [20:0]     off;
        logic [31:0]     word;
        logic [xlen-1:0] target;
        logic            tk;
        retireT          rec;
        kind      = int'({$random(seed)} % 16);
        rd        = pickReg();
        rs1       = pickReg();
        rs2       = pickReg();
        imm12     = 12'($random(seed));
        off       = 21'((int'({$random(seed)} % 32) - 16) * 4);
        target    = modelPc + {{11{off[20]}}, off};
        tk        = 1'b0;
        rec       = '0;
        rec.valid = 1'b1;
        rec.pc    = modelPc;
        rec.rd    = rd;
        if (kind < 8) begin
            op        = kind;
            word      = {(op == 1) ? 7'b0100000 : 7'b0000000, rs2, rs1, funct3For(op), rd,
                         7'b0110011};
            rec.write = 1'b1;
            rec.data  = aluModel(op, regs[rs1], regs[rs2]);
        end else if (kind < 13) begin
            // addi andi ori xori slti
            op        = (kind == 8) ? 0 : kind - 7;
            word      = {imm12, rs1, funct3For(op), rd, 7'b0010011};
            rec.write = 1'b1;
            rec.data  = aluModel(op, regs[rs1], {{20{imm12[11]}}, imm12});
        end else if (kind < 15) begin
            // beq for 13, bne for 14
            word = {off[12], off[10:5], rs2, rs1, (kind == 14) ? 3'b001 : 3'b000, off[4:1],
                    off[11], 7'b1100011};
            tk   = (kind == 14) ? (regs[rs1] != regs[rs2]) : (regs[rs1] == regs[rs2]);
        end else begin
            word      = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
            rec.write = 1'b1;
            rec.data  = modelPc + 32'd4;
            tk        = 1'b1;
        end
        if (rec.write && rd != 5'd0) begin
            regs[rd] = rec.data;
        end
        expRetire.push_back(rec);
        presentSlot(word, modelPc, 1'b1);
        if (tk) begin
            expTarget.push_back(target);
            modelPc = target;
            // Wrong-path addi that never retires
            presentSlot({imm12, pickReg(), 3'b000, pickReg(), 7'b0010011}, rec.pc + 32'd4, 1'b1);
        end else begin
            modelPc = modelPc + 32'd4;
        end
    endtask

    always @(negedge clk) begin
        retireT          want;
        logic [xlen-1:0] tgt;
        if (rstN) begin
            assert (!(retire.valid && hold))
                else stopWithFail($sformatf("Fail at %0t: retire.valid high during hold", $time));
            if (retire.valid) begin
                assert (expRetire.size() > 0)
                    else stopWithFail("A retire appeared with no instruction left to retire");
                want = expRetire.pop_front();
                assert (retire.pc == want.pc) else stopWithFail($sformatf(
                    "Fail at %0t: retire pc got %h expected %h", $time, retire.pc, want.pc));
                assert (retire.write == want.write) else stopWithFail($sformatf(
                    "Fail at %0t: retire write got %b expected %b at pc %h",
                    $time, retire.write, want.write, want.pc));
                if (want.write) begin
                    assert (retire.rd == want.rd) else stopWithFail($sformatf(
                        "Fail at %0t: retire rd got %0d expected %0d at pc %h",
                        $time, retire.rd, want.rd, want.pc));
                    assert (retire.data == want.data) else stopWithFail($sformatf(
                        "Fail at %0t: retire data got %h expected %h at pc %h",
                        $time, retire.data, want.data, want.pc));
                end
            end
            if (redirect.valid && !hold) begin
                assert (expTarget.size() > 0)
                    else stopWithFail("A redirect appeared with no taken branch or jal pending");
                tgt = expTarget.pop_front();
                assert (redirect.target == tgt) else stopWithFail($sformatf(
                    "Fail at %0t: redirect target got %h expected %h",
                    $time, redirect.target, tgt));
            end
        end
    end

    initial begin
        seed       = 32'h64b7_7e85;
        rstN       = 1'b0;
        hold       = 1'b0;
        instr      = '0;
        pc         = '0;
        instrValid = 1'b0;
        modelPc    = 32'h0000_1000;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        rstN = 1'b1;
        // A jal with valid low must neither retire nor redirect
        repeat (4) presentSlot({1'b0, 10'd4, 1'b0, 8'd0, 5'd1, 7'b1101111}, modelPc, 1'b0);
        repeat (500) begin
            if ({$random(seed)} % 10 == 0)
                presentSlot(32'($random(seed)), modelPc, 1'b0);
            else
                issueInstr();
        end
        instrValid = 1'b0;
        waitCycles = 0;
        while ((expRetire.size() != 0 || expTarget.size() != 0) && waitCycles < 20) begin
            @(posedge clk);
            #1;
            waitCycles++;
        end
        repeat (3) @(posedge clk);
        if (expRetire.size() == 0 && expTarget.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            stopWithFail("Timed out with expected retire records or redirects still pending");
        end
    end

endmodule

// ==== tb.f ====
source/corePkg.sv
source/controlUnit.sv
source/immExtend.sv
source/registerFile.sv
source/stageRegister.sv
source/executeUnit.sv
source/decodeExecSlice.sv
verification/tbDecodeExec.sv

// ==== Makefile ====
TOP = tbDecodeExec

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -f tb.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
